// File: hw/mvuPkg.sv
package mvuPkg;

	// lane geometry of one slice, fixed by the INT8 mode of the multiplier
	localparam int unsigned LaneCount = 3; // lanes per slice
	localparam int unsigned ActLaneWidth = 9; // activation lane after padding
	localparam int unsigned WgtLaneWidth = 8; // weight lane after padding

	// partial sums and the accumulator share one width
	localparam int unsigned SumWidth = 58;

	// one slice worth of padded activations, lane 0 in the low bits
	typedef logic [LaneCount*ActLaneWidth-1:0] sliceWord_t;

	// one slice worth of padded weights, same lane order
	typedef logic [LaneCount*WgtLaneWidth-1:0] wgtWord_t;

	// cascade and accumulator value
	typedef logic signed [SumWidth-1:0] sum_t;

	// Position of a slice in its chain. It decides whether the slice adds
	// the cascade input of its predecessor and whether it keeps the
	// running sum across beats.
	typedef enum logic [1:0] {
		FirstSlice, // no cascade in, no accumulation
		MidSlice, // cascade in, no accumulation
		LastSlice, // cascade in, accumulates
		SingleSlice // chain of one, accumulates without cascade
	} slicePos_e;

endpackage

// File: hw/mvuCtrlPipe.sv
module mvuCtrlPipe #(
	int unsigned NumSeg = 2 // cascade segments per chain
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic last_i,
	input logic zero_i,
	output logic vld_o,
	output logic accClear_o,
	output logic [NumSeg-1:0] zeroTap_o // bit s feeds segment s
);

	// operand stages of the deepest segment plus product and sum registers
	localparam int unsigned LastStages = NumSeg + 2;

	logic [LastStages-1:0] lastSr; // bit 0 holds the newest beat

	always_ff @(posedge clk) begin
		if (rst) begin
			lastSr <= '0;
		end else if (en_i) begin
			lastSr <= {lastSr[LastStages-2:0], last_i};
		end
	end

	assign vld_o = lastSr[LastStages-1]; // sum of the group is complete
	assign accClear_o = lastSr[LastStages-2]; // registered in the slice, clears next beat

	// first segment takes zero with its operands, no delay needed
	assign zeroTap_o[0] = zero_i;

	if (NumSeg > 1) begin : genZeroSr
		logic [NumSeg-2:0] zeroSr; // one stage per extra segment

		always_ff @(posedge clk) begin
			if (rst) begin
				zeroSr <= '0;
			end else if (en_i) begin
				zeroSr[0] <= zero_i;
				for (int s = 1; s < NumSeg - 1; s++) begin
					zeroSr[s] <= zeroSr[s-1];
				end
			end
		end

		assign zeroTap_o[NumSeg-1:1] = zeroSr;
	end

endmodule

// File: hw/operandSkew.sv
module operandSkew #(
	int unsigned Elems = 12, // vector length
	int unsigned ElemWidth = 8, // raw element width
	int unsigned LaneWidth = 9, // padded lane width
	bit SignExt = 1, // sign extension, else zero padding
	int unsigned SegLen = 2, // slices per cascade segment
	localparam int unsigned Slices = (Elems + mvuPkg::LaneCount - 1) / mvuPkg::LaneCount
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic [Elems-1:0][ElemWidth-1:0] elems_i,
	output logic [Slices-1:0][mvuPkg::LaneCount*LaneWidth-1:0] words_o
);
	import mvuPkg::*;

	for (genvar i = 0; i < Slices; i++) begin : genSlice
		localparam int unsigned Seg = i / SegLen; // segment of this slice
		localparam int unsigned ExtRegs = (Seg > 1) ? Seg - 1 : 0; // slice itself adds two
		localparam int unsigned Used = (i == Slices - 1) ? Elems - LaneCount*i : LaneCount;

		logic [Used-1:0][ElemWidth-1:0] raw; // elements after skew, before padding

		if (ExtRegs > 0) begin : genDelay
			logic [ExtRegs-1:0][Used-1:0][ElemWidth-1:0] dly;

			always_ff @(posedge clk) begin
				if (rst) begin
					dly <= '0;
				end else if (en_i) begin
					dly[0] <= elems_i[LaneCount*i +: Used];
					for (int s = 1; s < ExtRegs; s++) begin
						dly[s] <= dly[s-1];
					end
				end
			end

			assign raw = dly[ExtRegs-1];
		end else begin : genDirect
			assign raw = elems_i[LaneCount*i +: Used]; // early segments skew inside the slice
		end

		for (genvar j = 0; j < LaneCount; j++) begin : genLane
			if (j >= Used) begin : genIdle
				assign words_o[i][j*LaneWidth +: LaneWidth] = '0; // tail lanes multiply by zero
			end else if (SignExt) begin : genSext
				assign words_o[i][j*LaneWidth +: LaneWidth] = LaneWidth'($signed(raw[j]));
			end else begin : genZext
				assign words_o[i][j*LaneWidth +: LaneWidth] = LaneWidth'(raw[j]);
			end
		end
	end

endmodule

// File: hw/dotSlice.sv
module dotSlice #(
	mvuPkg::slicePos_e Pos = mvuPkg::FirstSlice,
	bit PReg = 1, // register the cascade output
	int unsigned OpStages = 1 // operand register depth, 1 or 2
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input mvuPkg::sliceWord_t act_i,
	input mvuPkg::wgtWord_t wgt_i,
	input logic zero_i, // already aligned to this segment
	input logic accClear_i,
	input mvuPkg::sum_t casc_i,
	output mvuPkg::sum_t casc_o
);
	import mvuPkg::*;

	localparam bit HasCasc = (Pos == MidSlice) || (Pos == LastSlice);
	localparam bit IsAcc = (Pos == LastSlice) || (Pos == SingleSlice);

	sliceWord_t [OpStages-1:0] actQ; // operand pipe
	wgtWord_t [OpStages-1:0] wgtQ;
	logic zeroQ; // zero flag next to the last operand stage
	sum_t prodSum; // three lane products, unregistered
	sum_t prodQ;
	sum_t stageSum; // product plus incoming cascade

	always_ff @(posedge clk) begin
		if (rst) begin
			actQ <= '0;
			wgtQ <= '0;
			zeroQ <= 1'b0;
		end else if (en_i) begin
			actQ[0] <= act_i;
			wgtQ[0] <= wgt_i;
			for (int s = 1; s < OpStages; s++) begin
				actQ[s] <= actQ[s-1];
				wgtQ[s] <= wgtQ[s-1];
			end
			zeroQ <= zero_i; // tap is one stage late already in later segments
		end
	end

	always_comb begin
		prodSum = '0;
		for (int k = 0; k < LaneCount; k++) begin
			prodSum = prodSum + $signed(actQ[OpStages-1][k*ActLaneWidth +: ActLaneWidth])
				* $signed(wgtQ[OpStages-1][k*WgtLaneWidth +: WgtLaneWidth]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			prodQ <= '0;
		end else if (en_i) begin
			prodQ <= zeroQ ? '0 : prodSum; // zeroed beat adds nothing
		end
	end

	assign stageSum = HasCasc ? prodQ + casc_i : prodQ;

	if (IsAcc) begin : genAcc
		logic accClearQ; // lines up with the first product of the next group
		sum_t accQ;

		always_ff @(posedge clk) begin
			if (rst) begin
				accClearQ <= 1'b0;
				accQ <= '0;
			end else if (en_i) begin
				accClearQ <= accClear_i;
				accQ <= (accClearQ ? '0 : accQ) + stageSum;
			end
		end

		assign casc_o = accQ;
	end else if (PReg) begin : genSegReg
		sum_t pQ; // breaks the cascade at the segment end

		always_ff @(posedge clk) begin
			if (rst) begin
				pQ <= '0;
			end else if (en_i) begin
				pQ <= stageSum;
			end
		end

		assign casc_o = pQ;
	end else begin : genPass
		assign casc_o = stageSum; // same segment continues combinationally
	end

endmodule

// File: hw/dotChain.sv
module dotChain #(
	int unsigned Simd = 12,
	int unsigned WgtWidth = 8,
	int unsigned AccuWidth = 24,
	int unsigned SegLen = 2,
	int unsigned ChainLen = 4, // slices in this chain
	int unsigned NumSeg = 2 // cascade segments
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input mvuPkg::sliceWord_t [ChainLen-1:0] actWords_i,
	input logic [Simd-1:0][WgtWidth-1:0] wgt_i,
	input logic [NumSeg-1:0] zeroTap_i,
	input logic accClear_i,
	output logic [AccuWidth-1:0] p_o
);
	import mvuPkg::*;

	wgtWord_t [ChainLen-1:0] wgtWords; // padded and skewed weight row
	sum_t casc [ChainLen+1]; // casc[j] enters slice j

	// weights are always signed
	operandSkew #(
		.Elems(Simd),
		.ElemWidth(WgtWidth),
		.LaneWidth(WgtLaneWidth),
		.SignExt(1'b1),
		.SegLen(SegLen)
	) wgtSkew_inst (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.elems_i(wgt_i),
		.words_o(wgtWords)
	);

	assign casc[0] = '0; // nothing ahead of the first slice

	for (genvar j = 0; j < ChainLen; j++) begin : genSlice
		localparam int unsigned Seg = j / SegLen;
		localparam slicePos_e Pos = slicePos_e'((ChainLen == 1) ? SingleSlice :
			(j == 0) ? FirstSlice : (j == ChainLen - 1) ? LastSlice : MidSlice);
		localparam bit PReg = ((j + 1) % SegLen == 0) || (j == ChainLen - 1); // segment end

		dotSlice #(
			.Pos(Pos),
			.PReg(PReg),
			.OpStages((Seg > 0) ? 2 : 1) // later segments wait one more cycle
		) dotSlice_inst (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.act_i(actWords_i[j]),
			.wgt_i(wgtWords[j]),
			.zero_i(zeroTap_i[Seg]),
			.accClear_i(accClear_i),
			.casc_i(casc[j]),
			.casc_o(casc[j+1])
		);
	end

	assign p_o = casc[ChainLen][AccuWidth-1:0]; // low bits of the accumulator

endmodule

// File: hw/mvuCore.sv
module mvuCore #(
	int unsigned Pe = 4, // number of dot-product chains
	int unsigned Simd = 12, // elements per vector
	int unsigned WgtWidth = 8, // at most 8
	int unsigned ActWidth = 8, // at most 9
	int unsigned AccuWidth = 24, // output slice of the 58-bit sum
	bit SignedAct = 1, // sign extend activations, else zero pad
	int unsigned SegLen = 2 // slices between cascade registers
) (
	input logic clk,
	input logic rst,
	input logic en_i, // freezes the whole pipe when low
	input logic last_i, // closes the current accumulation group
	input logic zero_i, // drop this beat's contribution
	input logic [Simd-1:0][ActWidth-1:0] a_i, // shared activation vector
	input logic [Pe*Simd-1:0][WgtWidth-1:0] w_i, // one weight row per PE
	output logic vld_o,
	output logic [Pe-1:0][AccuWidth-1:0] p_o
);
	import mvuPkg::*;

	localparam int unsigned ChainLen = (Simd + LaneCount - 1) / LaneCount; // slices per chain
	localparam int unsigned NumSeg = (ChainLen + SegLen - 1) / SegLen; // cascade segments

	logic accClear; // one stage ahead of vld
	logic [NumSeg-1:0] zeroTap; // zero flag aligned per segment
	sliceWord_t [ChainLen-1:0] actWords; // padded and skewed activations

	mvuCtrlPipe #(
		.NumSeg(NumSeg)
	) ctrlPipe_inst (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.last_i(last_i),
		.zero_i(zero_i),
		.vld_o(vld_o),
		.accClear_o(accClear),
		.zeroTap_o(zeroTap)
	);

	// activations are shared, so one skew line serves all chains
	operandSkew #(
		.Elems(Simd),
		.ElemWidth(ActWidth),
		.LaneWidth(ActLaneWidth),
		.SignExt(SignedAct),
		.SegLen(SegLen)
	) actSkew_inst (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.elems_i(a_i),
		.words_o(actWords)
	);

	for (genvar k = 0; k < Pe; k++) begin : genPe
		dotChain #(
			.Simd(Simd),
			.WgtWidth(WgtWidth),
			.AccuWidth(AccuWidth),
			.SegLen(SegLen),
			.ChainLen(ChainLen),
			.NumSeg(NumSeg)
		) dotChain_inst (
			.clk(clk),
			.rst(rst),
			.en_i(en_i),
			.actWords_i(actWords),
			.wgt_i(w_i[k*Simd +: Simd]), // row k of the weight matrix
			.zeroTap_i(zeroTap),
			.accClear_i(accClear),
			.p_o(p_o[k])
		);
	end

endmodule

// File: tests/mvuCore_checker.sv
module mvuCoreChecker #(
	int unsigned Pe = 4,
	int unsigned AccuWidth = 24,
	int unsigned NumSeg = 2 // cascade segments of the bound core
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic last_i,
	input logic vld_o,
	input logic [Pe-1:0][AccuWidth-1:0] p_o
);
	timeunit 1ns;
	timeprecision 1ps;

	int failures; // assertion failures so far

	// nothing leaves the pipe while reset holds, nor on the edge after it
	vldResetLow: assert property (@(posedge clk) rst |=> !vld_o ##1 !vld_o)
	else begin
		$error("vld_o went high during reset or on the first edge after it");
		failures++;
	end

	// a stalled cycle must not move the outputs
	outHold: assert property (@(posedge clk) disable iff (rst)
		!en_i |=> $stable(vld_o) && $stable(p_o))
	else begin
		$error("vld_o or p_o changed across a cycle with en_i low");
		failures++;
	end

	// result shows NumSeg+2 enabled edges after the last beat
	vldLatency: assert property (@(posedge clk) disable iff (rst)
		en_i && last_i |=> en_i [->NumSeg+1] ##1 vld_o)
	else begin
		$error("vld_o did not follow a last beat after the expected enabled edges");
		failures++;
	end

endmodule

// File: tests/mvuMonitor.sv
module mvuMonitor #(
	int unsigned Pe = 4,
	int unsigned AccuWidth = 24
) (
	input logic clk,
	input logic rst,
	input logic en_i, // a vld only counts once an enabled edge takes it
	input logic vld_i,
	input logic [Pe-1:0][AccuWidth-1:0] p_i,
	output int errors_o, // wrong result values
	output int pulses_o, // vld pulses seen
	output int expected_o // E rows in the stimulus file
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [Pe-1:0][AccuWidth-1:0] expRows[$]; // one entry per closed group

	// the E rows carry four results, p0 first
	initial begin
		int fd;
		string line;
		logic [AccuWidth-1:0] e0;
		logic [AccuWidth-1:0] e1;
		logic [AccuWidth-1:0] e2;
		logic [AccuWidth-1:0] e3;
		fd = $fopen("tests/mvu_stimulus.txt", "r");
		if (fd != 0) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] == "E") begin
					if ($sscanf(line, "E %h %h %h %h", e0, e1, e2, e3) == 4) begin
						expRows.push_back({e3, e2, e1, e0});
					end
				end
			end
			$fclose(fd);
		end
		expected_o = expRows.size();
	end

	// outputs settled half a cycle after the edge
	always @(negedge clk) begin
		if (!rst && vld_i && en_i) begin
			if (pulses_o >= expRows.size()) begin
				$display("vld pulse %0d arrived with no expected row left", pulses_o + 1);
			end else begin
				for (int k = 0; k < Pe; k++) begin
					if (p_i[k] !== expRows[pulses_o][k]) begin
						$display("FAILED p_o[%0d] in result %0d: got %h, expected %h",
							k, pulses_o, p_i[k], expRows[pulses_o][k]);
						errors_o++;
					end
				end
			end
			pulses_o++;
		end
	end

endmodule

// File: tests/mvuTb.sv
module mvuTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned Pe = 4;
	localparam int unsigned Simd = 12;
	localparam int unsigned WgtWidth = 8;
	localparam int unsigned ActWidth = 8;
	localparam int unsigned AccuWidth = 24;
	localparam int unsigned WRow = Simd * WgtWidth; // one weight row of the file

	logic clk = 1'b0;
	logic rst;
	logic en;
	logic last;
	logic zero;
	logic [Simd-1:0][ActWidth-1:0] a;
	logic [Pe*Simd-1:0][WgtWidth-1:0] w;
	logic vld;
	logic [Pe-1:0][AccuWidth-1:0] p;

	logic beatLast[$]; // beats as read from the B rows
	logic beatZero[$];
	logic [Simd*ActWidth-1:0] beatAct[$];
	logic [Pe*WRow-1:0] beatWgt[$];

	logic [31:0] lfsrState = 32'h6a58_6081;
	int cycles;
	int cycleLimit; // 0 until the beats are known
	int otherErrs;
	int valueErrs; // from the monitor
	int pulses;
	int expected;

	always #2 clk = ~clk; // 4 ns period

	mvuCore #(
		.Pe(Pe),
		.Simd(Simd),
		.WgtWidth(WgtWidth),
		.ActWidth(ActWidth),
		.AccuWidth(AccuWidth),
		.SignedAct(1'b1),
		.SegLen(2)
	) mvuCore_inst (
		.clk(clk),
		.rst(rst),
		.en_i(en),
		.last_i(last),
		.zero_i(zero),
		.a_i(a),
		.w_i(w),
		.vld_o(vld),
		.p_o(p)
	);

	mvuMonitor #(
		.Pe(Pe),
		.AccuWidth(AccuWidth)
	) monitor_inst (
		.clk(clk),
		.rst(rst),
		.en_i(en),
		.vld_i(vld),
		.p_i(p),
		.errors_o(valueErrs),
		.pulses_o(pulses),
		.expected_o(expected)
	);

	bind mvuCore mvuCoreChecker #(
		.Pe(Pe),
		.AccuWidth(AccuWidth),
		.NumSeg(NumSeg)
	) coreChecker_inst (
		.clk(clk),
		.rst(rst),
		.en_i(en_i),
		.last_i(last_i),
		.vld_o(vld_o),
		.p_o(p_o)
	);

	// galois step, returns the bit shifted out
	function automatic logic lfsrBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = (lfsrState >> 1) ^ (outBit ? 32'h8020_0003 : 32'h0);
		return outBit;
	endfunction

	// en high about three cycles in four
	function automatic logic randomEn();
		logic b0;
		logic b1;
		b0 = lfsrBit();
		b1 = lfsrBit();
		return b0 | b1;
	endfunction

	task automatic readBeats();
		int fd;
		string line;
		logic l;
		logic z;
		logic [Simd*ActWidth-1:0] av;
		logic [WRow-1:0] w0;
		logic [WRow-1:0] w1;
		logic [WRow-1:0] w2;
		logic [WRow-1:0] w3;
		fd = $fopen("tests/mvu_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/mvu_stimulus.txt");
			otherErrs++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line[0] == "B") begin
					if ($sscanf(line, "B %h %h %h %h %h %h %h", l, z, av, w0, w1, w2, w3) == 7) begin
						beatLast.push_back(l);
						beatZero.push_back(z);
						beatAct.push_back(av);
						beatWgt.push_back({w3, w2, w1, w0}); // row k lands at w_i[k*Simd +: Simd]
					end else begin
						$display("beat row could not be parsed: %s", line);
						otherErrs++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// hold one beat until an enabled edge takes it
	task automatic driveBeat(input int idx);
		logic taken;
		taken = 1'b0;
		while (!taken) begin
			#0.5;
			last = beatLast[idx];
			zero = beatZero[idx];
			a = beatAct[idx];
			w = beatWgt[idx];
			en = randomEn();
			taken = en;
			@(posedge clk);
		end
	endtask

	task automatic finishRun();
		int assertErrs;
		assertErrs = mvuCore_inst.coreChecker_inst.failures;
		$display("errors: %0d value, %0d assertion, %0d other", valueErrs, assertErrs, otherErrs);
		if (valueErrs == 0 && assertErrs == 0 && otherErrs == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		en = 1'b0;
		last = 1'b0;
		zero = 1'b0;
		a = '0;
		w = '0;
		readBeats();
		cycleLimit = 4 * beatLast.size() + 200;
		repeat (16) @(posedge clk);
		#0.5;
		rst = 1'b0;
		@(posedge clk);
		for (int i = 0; i < beatLast.size(); i++) begin
			driveBeat(i);
		end
		while (pulses < expected) begin // idle beats push the last group out
			#0.5;
			last = 1'b0;
			zero = 1'b0;
			a = '0;
			w = '0;
			en = randomEn();
			@(posedge clk);
		end
		#0.5;
		en = 1'b1;
		repeat (8) @(posedge clk); // window for stray vld pulses
		if (expected == 0) begin
			$display("stimulus file holds no expected rows");
			otherErrs++;
		end else if (pulses != expected) begin
			$display("saw %0d vld pulses for %0d expected rows", pulses, expected);
			otherErrs++;
		end
		finishRun();
	end

	always @(posedge clk) begin
		cycles++;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			otherErrs++;
			finishRun();
		end
	end

endmodule

// File: tests/mvu_stimulus.txt
# B last zero act[11:0] then weight rows of pe0..pe3, each packed hex with element 0 rightmost
# E expected p of pe0 pe1 pe2 pe3 after the last beat of the group above
# single beat, mixed rows
B 1 0 0c0b0a090807060504030201 010101010101010101010101 ffffffffffffffffffffffff 800000000000000000000000 00000000000002000000007f
E 00004e ffffb2 fffa00 00008b
# two beats, negative operands
B 0 0 ffffffffffffffffffffffff 010101010101010101010101 808080808080808080808080 000000000000000000000000 7f7f7f7f7f7f7f7f7f7f7f7f
B 1 0 020202020202020202020202 808080808080808080808080 010101010101010101010101 030303030303030303030303 ffffffffffffffffffffffff
E fff3f4 000618 000048 fff9f4
# three beats, the middle one zeroed
B 0 0 010101010101010101010101 010101010101010101010101 020202020202020202020202 030303030303030303030303 040404040404040404040404
B 0 1 7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f
B 1 0 808080808080808080808080 808080808080808080808080 7f7f7f7f7f7f7f7f7f7f7f7f 010101010101010101010101 000000000000000000000000
E 03000c fd0618 fffa24 000030
# zeroed single beat
B 1 1 0a0a0a0a0a0a0a0a0a0a0a0a 555555555555555555555555 555555555555555555555555 555555555555555555555555 555555555555555555555555
E 000000 000000 000000 000000
# extremes of the signed range
B 1 0 030000000000000005ff7f80 808080808080808080808080 7f7f7f7f7f7f7f7f7f7f7f7f ff0000000000000000000080 000000000000000000808000
E fffd00 0002fa 003ffd ffc100
# two equal beats
B 0 0 010101010101010101010101 010101010101010101010101 020202020202020202020202 030303030303030303030303 040404040404040404040404
B 1 0 010101010101010101010101 010101010101010101010101 020202020202020202020202 030303030303030303030303 040404040404040404040404
E 000018 000030 000048 000060

// File: all.f
hw/mvuPkg.sv
hw/mvuCtrlPipe.sv
hw/operandSkew.sv
hw/dotSlice.sv
hw/dotChain.sv
hw/mvuCore.sv
tests/mvuCore_checker.sv
tests/mvuMonitor.sv
tests/mvuTb.sv

// File: Bender.yml
package:
  name: mvu

sources:
  - hw/mvuPkg.sv
  - hw/mvuCtrlPipe.sv
  - hw/operandSkew.sv
  - hw/dotSlice.sv
  - hw/dotChain.sv
  - hw/mvuCore.sv
  - target: test
    files:
      - tests/mvuCore_checker.sv
      - tests/mvuMonitor.sv
      - tests/mvuTb.sv
